// File: Makefile
TOP = eth_tx_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o eth_tx_sim
	@out="$$(./obj_dir/eth_tx_sim)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: common/eth_tx_defines.svh
`ifndef ETH_TX_DEFINES_SVH
`define ETH_TX_DEFINES_SVH

// ------------------------------
// packet ring geometry
// ------------------------------
`define ETH_TX_SLOT_BYTES     64
`define ETH_TX_SLOTS          4
`define ETH_TX_OFFSET_W       6
`define ETH_TX_SLOT_W         2
`define ETH_TX_LEN_W          7       // holds 0 to 64

// ------------------------------
// wishbone register map
// ------------------------------
`define ETH_TX_WB_ADR_W       7
`define ETH_TX_REG_COMMIT     7'h40
`define ETH_TX_REG_FILL_LEN   7'h41
`define ETH_TX_REG_STATUS     7'h42

// frame constants
`define ETH_TX_PREAMBLE_BYTE  8'h55
`define ETH_TX_SFD_BYTE       8'hD5
`define ETH_TX_PREAMBLE_LEN   7
`define ETH_TX_GAP_CYCLES     12

`endif

// File: common/eth_tx_pkg.sv
`include "eth_tx_defines.svh"

package eth_tx_pkg;

    typedef logic [7:0] eth_byte_t;

    typedef struct packed {
        logic                         cyc;
        logic                         stb;
        logic                         we;
        logic [`ETH_TX_WB_ADR_W-1:0]  adr;
        logic [31:0]                  dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic                         byte_we;
        logic                         commit;
        logic [`ETH_TX_OFFSET_W-1:0]  offset;
        eth_byte_t                    data;
    } ring_wr_t;

    typedef struct packed {
        logic [`ETH_TX_LEN_W-1:0]     fill_len;
        logic [`ETH_TX_SLOT_W:0]      queued;
        logic                         full;
    } ring_info_t;

    typedef struct packed {
        logic                         pending;
        logic [`ETH_TX_LEN_W-1:0]     length;
        eth_byte_t                    data;
    } ring_rd_t;

    typedef struct packed {
        logic [`ETH_TX_OFFSET_W-1:0]  offset;
        logic                         release_slot;   // slot fully sent
    } framer_req_t;

    typedef struct packed {
        logic                         range_err;
        logic                         commit_drop;
        logic                         full;
        logic [`ETH_TX_SLOT_W:0]      queued;
    } tx_status_t;

    typedef struct packed {
        eth_byte_t                    txd;
        logic                         tx_en;
        logic                         tx_er;
    } gmii_tx_t;

    // running fcs, whole word or bytes in line order
    typedef union packed {
        logic [31:0]     value;
        eth_byte_t [3:0] bytes;
    } crc_word_u;

    localparam logic [31:0] CRC32_POLY = 32'hEDB8_8320;   // reflected 802.3

    // one byte through the reflected crc, lsb first
    function automatic logic [31:0] crc32_next_byte(input logic [31:0] crc,
                                                    input eth_byte_t data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++)
        begin
            c = c[0] ? ((c >> 1) ^ CRC32_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage

// File: dv/eth_tx_assert.sv
`timescale 1ns/1ps
`include "eth_tx_defines.svh"

module eth_tx_assert import eth_tx_pkg::*; (
    input logic     clock,
    input logic     reset,
    input wb_req_t  wb_req,
    input wb_rsp_t  wb_rsp,
    input gmii_tx_t gmii
);

    int idle_run;         // tx_en low cycles since the last frame, saturating
    int fail_count = 0;   // failed properties so far

    always_ff @(posedge clock)
    begin
        if (reset)
            idle_run <= `ETH_TX_GAP_CYCLES;
        else if (gmii.tx_en)
            idle_run <= 0;
        else if (idle_run < `ETH_TX_GAP_CYCLES)
            idle_run <= idle_run + 1;
    end

    // ------------------------------
    // wishbone
    // ------------------------------
    ack_single: assert property (@(posedge clock) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else
        begin
            fail_count++;
            $error("ack high for two cycles running");
        end

    ack_after_stb: assert property (@(posedge clock) disable iff (reset)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else
        begin
            fail_count++;
            $error("ack without a preceding cyc and stb");
        end

    // gmii
    tx_er_low: assert property (@(posedge clock) disable iff (reset) !gmii.tx_er)
        else
        begin
            fail_count++;
            $error("tx_er raised");
        end

    gap_held: assert property (@(posedge clock) disable iff (reset)
        $rose(gmii.tx_en) |-> (idle_run >= `ETH_TX_GAP_CYCLES))
        else
        begin
            fail_count++;
            $error("interframe gap shorter than 12 cycles");
        end

endmodule

bind eth_tx_top eth_tx_assert i_eth_tx_assert (
    .clock  (clock),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .gmii   (gmii)
);

// File: dv/eth_tx_tb.sv
`timescale 1ns/1ps
`include "eth_tx_defines.svh"

module eth_tx_tb import eth_tx_pkg::*; ();

    localparam int FRAME_CYCLES = 523;       // preamble, data, fcs and gap of every frame
    localparam int WB_CYCLES    = 2 * 90;    // two cycles per wishbone access
    localparam int CYCLE_LIMIT  = 4 * (FRAME_CYCLES + WB_CYCLES);

    logic     clock;
    logic     reset;
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;
    gmii_tx_t gmii;

    eth_byte_t   rx_q[$];          // line bytes of all frames, in order
    int          frame_lens[$];
    int          cur_len = 0;
    int          idle_run = 0;
    int          gap_errors = 0;
    int          test_errors = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    logic [31:0] lcg_state = 32'd18;

    eth_tx_top i_eth_tx_top (
        .clock  (clock),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .gmii   (gmii)
    );

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // ------------------------------
    // gmii monitor
    // ------------------------------
    always @(negedge clock)
    begin
        if (reset)
        begin
            cur_len  = 0;
            idle_run = `ETH_TX_GAP_CYCLES;
        end
        else if (gmii.tx_en)
        begin
            if (cur_len == 0 && idle_run < `ETH_TX_GAP_CYCLES)
                gap_errors++;
            rx_q.push_back(gmii.txd);
            cur_len++;
            idle_run = 0;
        end
        else
        begin
            if (cur_len != 0)
                frame_lens.push_back(cur_len);   // frame just ended
            cur_len = 0;
            idle_run++;
        end
    end

    function automatic eth_byte_t next_random_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // ------------------------------
    // wishbone driver
    // ------------------------------
    task automatic wb_cycle(input logic we, input logic [`ETH_TX_WB_ADR_W-1:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge clock);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = wdata;
        do
            @(negedge clock);
        while (!wb_rsp.ack);
        rdata      = wb_rsp.dat_r;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_write(input logic [`ETH_TX_WB_ADR_W-1:0] adr, input logic [31:0] data);
        logic [31:0] ignored;
        wb_cycle(1'b1, adr, data, ignored);
    endtask

    task automatic wb_read(input logic [`ETH_TX_WB_ADR_W-1:0] adr, output logic [31:0] data);
        wb_cycle(1'b0, adr, 32'd0, data);
    endtask

    // ------------------------------
    // compare and report
    // ------------------------------
    task automatic check_byte(input string name, input eth_byte_t exp, input eth_byte_t act);
        if (act !== exp)
        begin
            test_errors++;
            $display("mismatch %s: expected %02h, actual %02h", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input tx_status_t exp, input tx_status_t act);
        if (act !== exp)
        begin
            test_errors++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_len(input string name, input logic [`ETH_TX_LEN_W-1:0] exp,
                             input logic [`ETH_TX_LEN_W-1:0] act);
        if (act !== exp)
        begin
            test_errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
        begin
            test_errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0)
            $display("%s: ok", name);
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic wait_frames(input int n);
        while (frame_lens.size() < n)
            @(negedge clock);
        repeat (`ETH_TX_GAP_CYCLES + 2)
            @(negedge clock);
    endtask

    // expected frame: preamble, sfd, data, complemented reflected crc lsb first
    task automatic check_frame(input string name, input eth_byte_t data[$]);
        logic [31:0] fcs;
        eth_byte_t   exp_q[$];
        eth_byte_t   got;
        int          n;
        fcs = 32'hFFFF_FFFF;
        foreach (data[i])
        begin
            for (int b = 0; b < 8; b++)
                fcs = (fcs[0] ^ data[i][b]) ? ((fcs >> 1) ^ 32'hEDB8_8320) : (fcs >> 1);
        end
        fcs = ~fcs;
        repeat (`ETH_TX_PREAMBLE_LEN)
            exp_q.push_back(`ETH_TX_PREAMBLE_BYTE);
        exp_q.push_back(`ETH_TX_SFD_BYTE);
        foreach (data[i])
            exp_q.push_back(data[i]);
        for (int k = 0; k < 4; k++)
            exp_q.push_back(fcs[8*k +: 8]);
        n = frame_lens.pop_front();
        check_count({name, " length"}, exp_q.size(), n);
        for (int i = 0; i < n; i++)
        begin
            got = rx_q.pop_front();
            if (n == exp_q.size())
                check_byte(name, exp_q[i], got);
        end
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic run_single_frame();
        eth_byte_t data[$];
        for (int i = 0; i < 20; i++)
        begin
            data.push_back(next_random_byte());
            wb_write(7'(i), {24'd0, data[i]});
        end
        wb_write(`ETH_TX_REG_COMMIT, 32'd0);
        wait_frames(1);
        check_frame("single frame", data);
        report_test("single frame");
    endtask

    task automatic run_fill_len_range();
        logic [31:0] rd;
        tx_status_t  exp;
        wb_write(7'd5, 32'hA5);
        wb_write(7'd2, 32'h5A);
        wb_read(`ETH_TX_REG_FILL_LEN, rd);
        check_len("fill length", 7'd6, rd[`ETH_TX_LEN_W-1:0]);
        wb_write(7'h43, 32'hFF);   // past the slot and the register block
        wb_read(`ETH_TX_REG_STATUS, rd);
        exp           = '0;
        exp.range_err = 1'b1;
        check_status("range error set", exp, tx_status_t'(rd[$bits(tx_status_t)-1:0]));
        wb_read(`ETH_TX_REG_STATUS, rd);
        check_status("range error cleared", '0, tx_status_t'(rd[$bits(tx_status_t)-1:0]));
        report_test("fill length and range error");
    endtask

    task automatic run_back_to_back();
        int          lens[3];
        int          base;
        eth_byte_t   all_q[$];
        logic [31:0] rd;
        lens = '{30, 12, 5};
        foreach (lens[p])
        begin
            for (int i = 0; i < lens[p]; i++)
            begin
                all_q.push_back(next_random_byte());
                wb_write(7'(i), {24'd0, all_q[$]});
            end
            wb_write(`ETH_TX_REG_COMMIT, 32'd0);
        end
        wait_frames(3);
        base = 0;
        foreach (lens[p])
        begin
            check_frame("back-to-back", all_q[base:base+lens[p]-1]);
            base += lens[p];
        end
        check_count("back-to-back short gaps", 0, gap_errors);
        wb_read(`ETH_TX_REG_STATUS, rd);
        check_status("back-to-back status", '0, tx_status_t'(rd[$bits(tx_status_t)-1:0]));
        report_test("back-to-back queue");
    endtask

    task automatic run_full_ring();
        logic [31:0] rd;
        tx_status_t  exp;
        for (int p = 0; p < `ETH_TX_SLOTS; p++)
        begin
            wb_write(7'd59, 32'h3C);   // 60 bytes, older contents stay
            wb_write(`ETH_TX_REG_COMMIT, 32'd0);
        end
        wb_write(`ETH_TX_REG_COMMIT, 32'd0);
        wb_read(`ETH_TX_REG_STATUS, rd);
        exp             = '0;
        exp.commit_drop = 1'b1;
        exp.full        = 1'b1;
        exp.queued      = 3'(`ETH_TX_SLOTS);
        check_status("full ring status", exp, tx_status_t'(rd[$bits(tx_status_t)-1:0]));
        wait_frames(`ETH_TX_SLOTS);
        // long enough for a stray fifth frame to end
        repeat (`ETH_TX_SLOT_BYTES + 2 * `ETH_TX_GAP_CYCLES)
            @(negedge clock);
        check_count("full ring frames", `ETH_TX_SLOTS, frame_lens.size());
        check_count("full ring line bytes", `ETH_TX_SLOTS * 72, rx_q.size());
        while (frame_lens.size() != 0)
            check_count("full ring frame length", 72, frame_lens.pop_front());
        rx_q.delete();
        report_test("full ring");
    endtask

    task automatic run_empty_packet();
        eth_byte_t   none[$];
        logic [31:0] rd;
        wb_read(`ETH_TX_REG_FILL_LEN, rd);
        check_len("empty fill length", '0, rd[`ETH_TX_LEN_W-1:0]);
        wb_write(`ETH_TX_REG_COMMIT, 32'd0);
        wait_frames(1);
        check_frame("empty packet", none);
        report_test("empty packet");
    endtask

    initial
    begin
        wb_req = '0;
        reset  = 1'b1;
        repeat (2) @(negedge clock);
        reset = 1'b0;
        run_single_frame();
        run_fill_len_range();
        run_back_to_back();
        run_full_ring();
        run_empty_packet();
        $display("tests run %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, i_eth_tx_top.i_eth_tx_assert.fail_count);
        if (tests_failed == 0 && errors == 0 && i_eth_tx_top.i_eth_tx_assert.fail_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // watchdog
    initial
    begin
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: logic/eth_tx_top.sv
`timescale 1ns/1ps

module eth_tx_top import eth_tx_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    output gmii_tx_t gmii
);

    ring_wr_t    ring_wr;
    ring_info_t  ring_info;
    ring_rd_t    ring_rd;
    framer_req_t framer_req;

    // host side
    host_port i_host_port (
        .clock     (clock),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .ring_wr   (ring_wr),
        .ring_info (ring_info)
    );

    packet_ring i_packet_ring (
        .clock      (clock),
        .reset      (reset),
        .ring_wr    (ring_wr),
        .ring_info  (ring_info),
        .framer_req (framer_req),
        .ring_rd    (ring_rd)
    );

    // line side
    tx_framer i_tx_framer (
        .clock      (clock),
        .reset      (reset),
        .ring_rd    (ring_rd),
        .framer_req (framer_req),
        .gmii       (gmii)
    );

endmodule

// File: logic/host_port.sv
`timescale 1ns/1ps
`include "eth_tx_defines.svh"

module host_port import eth_tx_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  wb_req_t    wb_req,
    output wb_rsp_t    wb_rsp,
    output ring_wr_t   ring_wr,
    input  ring_info_t ring_info
);

    logic        ack;
    logic [31:0] dat_r;
    logic        range_err;
    logic        commit_drop;
    logic        access;
    logic        wr_access;
    logic        rd_access;
    logic        is_commit;
    logic        is_fill_len;
    logic        is_status;
    logic        is_byte;
    logic        in_range;
    tx_status_t  status;
    logic [31:0] rd_value;

    // ------------------------------
    // address decode
    // ------------------------------
    assign access    = wb_req.cyc && wb_req.stb && !ack;   // first sampled cycle only
    assign wr_access = access && wb_req.we;
    assign rd_access = access && !wb_req.we;

    assign is_commit   = (wb_req.adr == `ETH_TX_REG_COMMIT);
    assign is_fill_len = (wb_req.adr == `ETH_TX_REG_FILL_LEN);
    assign is_status   = (wb_req.adr == `ETH_TX_REG_STATUS);

    // anything off the register map is a byte offset, possibly out of range
    assign is_byte  = !(is_commit || is_fill_len || is_status);
    assign in_range = (wb_req.adr < `ETH_TX_SLOT_BYTES);

    always_comb
    begin
        ring_wr.byte_we = wr_access && is_byte && in_range && !ring_info.full;
        ring_wr.commit  = wr_access && is_commit && !ring_info.full;
        ring_wr.offset  = wb_req.adr[`ETH_TX_OFFSET_W-1:0];
        ring_wr.data    = wb_req.dat_w[7:0];
    end

    // ------------------------------
    // read mux
    // ------------------------------
    always_comb
    begin
        status.range_err   = range_err;
        status.commit_drop = commit_drop;
        status.full        = ring_info.full;
        status.queued      = ring_info.queued;
        rd_value           = '0;
        if (is_status)
            rd_value[$bits(tx_status_t)-1:0] = status;
        else if (is_fill_len)
            rd_value[`ETH_TX_LEN_W-1:0] = ring_info.fill_len;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            ack         <= 1'b0;
            range_err   <= 1'b0;
            commit_drop <= 1'b0;
        end
        else
        begin
            ack <= access;
            if (rd_access && is_status)
            begin
                range_err   <= 1'b0;   // cleared once reported
                commit_drop <= 1'b0;
            end
            if (wr_access && is_byte && (!in_range || ring_info.full))
                range_err <= 1'b1;
            if (wr_access && is_commit && ring_info.full)
                commit_drop <= 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (rd_access)
            dat_r <= rd_value;
    end

    always_comb
    begin
        wb_rsp.ack   = ack;
        wb_rsp.dat_r = dat_r;
    end

endmodule

// File: packet_ring/packet_ring.sv
`timescale 1ns/1ps
`include "eth_tx_defines.svh"

module packet_ring import eth_tx_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  ring_wr_t    ring_wr,
    output ring_info_t  ring_info,
    input  framer_req_t framer_req,
    output ring_rd_t    ring_rd
);

    eth_byte_t                 slot_mem [`ETH_TX_SLOTS][`ETH_TX_SLOT_BYTES];
    logic [`ETH_TX_LEN_W-1:0]  slot_len [`ETH_TX_SLOTS];

    logic [`ETH_TX_SLOT_W-1:0] wr_slot;      // slot being filled by the host
    logic [`ETH_TX_SLOT_W-1:0] rd_slot;      // slot being sent
    logic [`ETH_TX_SLOT_W-1:0] wr_slot_next;
    logic [`ETH_TX_SLOT_W:0]   count;
    logic                      pending;
    logic [`ETH_TX_LEN_W-1:0]  wr_end;

    assign wr_slot_next = wr_slot + 1'b1;
    assign wr_end       = {1'b0, ring_wr.offset} + 1'b1;

    // ------------------------------
    // slot storage
    // ------------------------------
    always_ff @(posedge clock)
    begin
        if (ring_wr.byte_we)
            slot_mem[wr_slot][ring_wr.offset] <= ring_wr.data;
    end

    // length only grows while filling
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < `ETH_TX_SLOTS; i++)
            begin
                slot_len[i] <= '0;
            end
        end
        else
        begin
            if (ring_wr.byte_we && (wr_end > slot_len[wr_slot]))
                slot_len[wr_slot] <= wr_end;
            if (ring_wr.commit)
                slot_len[wr_slot_next] <= '0;   // fresh fill slot
        end
    end

    // ------------------------------
    // slot pointers
    // ------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wr_slot <= '0;
            rd_slot <= '0;
            count   <= '0;
            pending <= 1'b0;
        end
        else
        begin
            if (ring_wr.commit)
                wr_slot <= wr_slot_next;
            if (framer_req.release_slot)
                rd_slot <= rd_slot + 1'b1;
            case ({ring_wr.commit, framer_req.release_slot})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            pending <= (count != '0);   // lags the count by a cycle
        end
    end

    always_comb
    begin
        ring_info.fill_len = slot_len[wr_slot];
        ring_info.queued   = count;
        ring_info.full     = (count == `ETH_TX_SLOTS);
    end

    always_comb
    begin
        ring_rd.pending = pending;
        ring_rd.length  = slot_len[rd_slot];
        ring_rd.data    = slot_mem[rd_slot][framer_req.offset];
    end

endmodule

// File: sim.f
+incdir+common
common/eth_tx_pkg.sv
tx_framer/crc32_engine.sv
tx_framer/tx_framer.sv
packet_ring/packet_ring.sv
logic/host_port.sv
logic/eth_tx_top.sv
dv/eth_tx_assert.sv
dv/eth_tx_tb.sv

// File: tx_framer/crc32_engine.sv
`timescale 1ns/1ps

module crc32_engine import eth_tx_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      clear,
    input  logic      data_valid,
    input  eth_byte_t data,
    output crc_word_u crc
);

    logic [31:0] crc_next;

    // ------------------------------
    // byte-wide fcs update
    // ------------------------------
    assign crc_next = crc32_next_byte(crc.value, data);

    always_ff @(posedge clock)
    begin
        if (reset || clear)
        begin
            crc.value <= '1;   // 802.3 seed
        end
        else if (data_valid)
        begin
            crc.value <= crc_next;
        end
    end

endmodule

// File: tx_framer/tx_framer.sv
`timescale 1ns/1ps
`include "eth_tx_defines.svh"

module tx_framer import eth_tx_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  ring_rd_t    ring_rd,
    output framer_req_t framer_req,
    output gmii_tx_t    gmii
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_SFD,
        ST_DATA,
        ST_FCS,
        ST_GAP
    } state_t;

    localparam logic [3:0] PRE_LAST = 4'(`ETH_TX_PREAMBLE_LEN - 1);
    localparam logic [3:0] FCS_LAST = 4'd3;
    localparam logic [3:0] GAP_LAST = 4'(`ETH_TX_GAP_CYCLES - 2);   // idle is the last one

    state_t                      state;
    logic [3:0]                  count;
    logic [`ETH_TX_LEN_W-1:0]    length;
    logic [`ETH_TX_OFFSET_W-1:0] offset;
    logic                        last_data;
    crc_word_u                   crc;

    assign last_data = ({1'b0, offset} == (length - 1'b1));

    // ------------------------------
    // frame sequencer
    // ------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state  <= ST_IDLE;
            count  <= '0;
            offset <= '0;
        end
        else
        begin
            count <= count + 1'b1;
            case (state)
                ST_IDLE:
                begin
                    count <= '0;
                    if (ring_rd.pending)
                        state <= ST_PREAMBLE;
                end
                ST_PREAMBLE:
                    if (count == PRE_LAST)
                        state <= ST_SFD;
                ST_SFD:
                begin
                    count  <= '0;
                    offset <= '0;
                    state  <= (length == '0) ? ST_FCS : ST_DATA;   // empty packet
                end
                ST_DATA:
                begin
                    count  <= '0;
                    offset <= offset + 1'b1;
                    if (last_data)
                        state <= ST_FCS;
                end
                ST_FCS:
                    if (count == FCS_LAST)
                    begin
                        count <= '0;
                        state <= ST_GAP;
                    end
                ST_GAP:
                    if (count == GAP_LAST)
                        state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if ((state == ST_IDLE) && ring_rd.pending)
            length <= ring_rd.length;
    end

    crc32_engine i_crc32_engine (
        .clock      (clock),
        .reset      (reset),
        .clear      (state == ST_IDLE),
        .data_valid (state == ST_DATA),
        .data       (ring_rd.data),
        .crc        (crc)
    );

    // ------------------------------
    // gmii and ring outputs
    // ------------------------------
    always_comb
    begin
        gmii.tx_er = 1'b0;
        gmii.tx_en = 1'b0;
        gmii.txd   = '0;
        case (state)
            ST_PREAMBLE:
            begin
                gmii.tx_en = 1'b1;
                gmii.txd   = `ETH_TX_PREAMBLE_BYTE;
            end
            ST_SFD:
            begin
                gmii.tx_en = 1'b1;
                gmii.txd   = `ETH_TX_SFD_BYTE;
            end
            ST_DATA:
            begin
                gmii.tx_en = 1'b1;
                gmii.txd   = ring_rd.data;
            end
            ST_FCS:
            begin
                gmii.tx_en = 1'b1;
                gmii.txd   = ~crc.bytes[count[1:0]];   // low byte goes first
            end
            default:
                gmii.tx_en = 1'b0;
        endcase
    end

    always_comb
    begin
        framer_req.offset       = offset;
        framer_req.release_slot = (state == ST_FCS) && (count == FCS_LAST);
    end

endmodule
